/* tb/config_chain_golden.txt */
# op id data gap exp_cfg0 exp_cfg1 exp_cfg2, all hex
# gap 8 picks a random gap of 0 to 7 cycles, other values are used as given
3 1 00 8 5A 11 5
0 1 3C 8 3C 11 5
0 2 FF 8 3C 1F 5
0 3 FF 8 3C 1F 7
0 7 00 8 3C 1F 7
3 2 00 8 3C 1F 7
1 2 00 8 3C 11 7
0 3 02 8 3C 11 2
1 1 00 8 5A 11 2
0 1 A5 8 A5 11 2
2 9 00 8 5A 11 5
0 1 01 0 01 11 5
0 2 0A 0 01 0A 5
0 3 0B 0 01 0A 3
0 2 E6 0 01 06 3
2 0 00 0 5A 11 5
0 1 77 8 77 11 5

/* sources.f */
logic/config_pkg.sv
logic/config_serializer.sv
logic/config_node.sv
logic/config_chain_top.sv
tb/config_chain_checker.sv
tb/config_chain_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= config_chain_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Everything OK
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb/config_chain_tb.sv */
`timescale 1ns/1ps

module config_chain_tb;

  localparam int period_lp = 40;
  localparam int settle_lp = 15 + 2;   // Frame length plus chain depth

  logic                  clk;
  logic                  reset;
  logic                  send;
  config_pkg::op_t       op;
  config_pkg::node_id_t  node_id;
  config_pkg::cfg_data_t data;
  logic                  busy;
  logic [7:0]            cfg0;
  logic [4:0]            cfg1;
  logic [2:0]            cfg2;

  logic                  check;
  int                    check_num;
  logic [7:0]            exp0;
  logic [4:0]            exp1;
  logic [2:0]            exp2;
  int                    pass_count;
  int                    fail_count;
  int                    busy_errors;
  int                    checks_done;

  logic [7:0]            vec_op[$];
  logic [7:0]            vec_id[$];
  logic [7:0]            vec_data[$];
  logic [7:0]            vec_gap[$];
  logic [7:0]            vec_exp0[$];
  logic [7:0]            vec_exp1[$];
  logic [7:0]            vec_exp2[$];
  logic                  loaded;

  config_chain_top dut0 (
    .clk_i     (clk),
    .reset_i   (reset),
    .send_i    (send),
    .op_i      (op),
    .node_id_i (node_id),
    .data_i    (data),
    .busy_o    (busy),
    .cfg0_o    (cfg0),
    .cfg1_o    (cfg1),
    .cfg2_o    (cfg2)
  );

  config_chain_checker chk0 (
    .clk_i            (clk),
    .reset_i          (reset),
    .check_i          (check),
    .test_num_i       (check_num),
    .exp0_i           (exp0),
    .exp1_i           (exp1),
    .exp2_i           (exp2),
    .send_i           (send),
    .busy_i           (busy),
    .cfg0_i           (cfg0),
    .cfg1_i           (cfg1),
    .cfg2_i           (cfg2),
    .pass_count_o     (pass_count),
    .fail_count_o     (fail_count),
    .busy_err_count_o (busy_errors)
  );

  always #(period_lp / 2) clk = ~clk;

  task automatic load_vectors();
    int    fd;
    int    n;
    string line;
    logic [7:0] f[7];
    fd = $fopen("tb/config_chain_golden.txt", "r");
    if (fd == 0) begin
      $display("cannot open tb/config_chain_golden.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() < 2 || line.getc(0) == "#") begin
          continue;
        end
        n = $sscanf(line, "%h %h %h %h %h %h %h", f[0], f[1], f[2], f[3], f[4], f[5], f[6]);
        if (n == 7) begin
          vec_op.push_back(f[0]);
          vec_id.push_back(f[1]);
          vec_data.push_back(f[2]);
          vec_gap.push_back(f[3]);
          vec_exp0.push_back(f[4]);
          vec_exp1.push_back(f[5]);
          vec_exp2.push_back(f[6]);
        end
      end
      $fclose(fd);
    end
  endtask

  // Runs alongside later frames so back-to-back sends are not held up
  task automatic schedule_check(int num, logic [7:0] e0, logic [4:0] e1, logic [2:0] e2);
    fork
      begin
        repeat (settle_lp + 1) @(posedge clk);   // First edge is the one taking the strobe
        @(negedge clk);
        check_num = num;
        exp0      = e0;
        exp1      = e1;
        exp2      = e2;
        check     = 1'b1;
        @(negedge clk);
        check       = 1'b0;
        checks_done = checks_done + 1;
      end
    join_none
  endtask

  task automatic send_frame(int idx);
    int gap;
    @(negedge clk);
    while (busy) begin
      @(negedge clk);
    end
    gap = (vec_gap[idx] == 8'h8) ? int'($urandom_range(7, 0)) : int'(vec_gap[idx]);
    repeat (gap) @(negedge clk);                 // Idle cycles after busy falls
    send    = 1'b1;
    op      = vec_op[idx][1:0];
    node_id = vec_id[idx][3:0];
    data    = vec_data[idx];
    schedule_check(idx + 1, vec_exp0[idx], vec_exp1[idx][4:0], vec_exp2[idx][2:0]);
    @(negedge clk);
    send = 1'b0;
  endtask

  initial begin
    void'($urandom(6));
    clk         = 1'b0;
    reset       = 1'b1;
    send        = 1'b0;
    op          = '0;
    node_id     = '0;
    data        = '0;
    check       = 1'b0;
    check_num   = 0;
    exp0        = '0;
    exp1        = '0;
    exp2        = '0;
    checks_done = 0;
    loaded      = 1'b0;
    load_vectors();
    loaded = 1'b1;
    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    for (int i = 0; i < vec_op.size(); i++) begin
      send_frame(i);
    end
    wait (checks_done == vec_op.size());
    repeat (2) @(posedge clk);
    $display("tests: %0d run, %0d passed, %0d failed, %0d busy errors",
             vec_op.size(), pass_count, fail_count, busy_errors);
    if (fail_count == 0 && busy_errors == 0 && pass_count == vec_op.size() &&
        vec_op.size() > 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // Watchdog sized from the number of frames
  initial begin
    longint limit;
    wait (loaded);
    limit = (longint'(vec_op.size()) * (15 + 8 + 20) + 10) * period_lp;
    #(limit);
    $display("watchdog timeout: tests did not finish");
    $display("Something failed");
    $finish;
  end

endmodule

/* tb/config_chain_checker.sv */
`timescale 1ns/1ps

module config_chain_checker (
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       check_i,       // One-cycle strobe from the testbench
  input  int         test_num_i,
  input  logic [7:0] exp0_i,
  input  logic [4:0] exp1_i,
  input  logic [2:0] exp2_i,
  input  logic       send_i,
  input  logic       busy_i,
  input  logic [7:0] cfg0_i,
  input  logic [4:0] cfg1_i,
  input  logic [2:0] cfg2_i,
  output int         pass_count_o,
  output int         fail_count_o,
  output int         busy_err_count_o
);

  localparam int frame_cycles_lp = 15;   // Busy length of one frame

  int busy_left;                         // Busy cycles still owed to the frame in flight

  initial begin
    pass_count_o     = 0;
    fail_count_o     = 0;
    busy_err_count_o = 0;
  end

  // Outputs sampled on the rising edge that sees the strobe
  always @(posedge clk_i) begin
    if (check_i) begin
      if ((cfg0_i === exp0_i) && (cfg1_i === exp1_i) && (cfg2_i === exp2_i)) begin
        pass_count_o <= pass_count_o + 1;
        $display("test %0d: pass (cfg0_o=%h cfg1_o=%h cfg2_o=%h)",
                 test_num_i, cfg0_i, cfg1_i, cfg2_i);
      end else begin
        fail_count_o <= fail_count_o + 1;
        if (cfg0_i !== exp0_i) begin
          $display("MISMATCH test %0d cfg0_o: expected %h, got %h",
                   test_num_i, exp0_i, cfg0_i);
        end
        if (cfg1_i !== exp1_i) begin
          $display("MISMATCH test %0d cfg1_o: expected %h, got %h",
                   test_num_i, exp1_i, cfg1_i);
        end
        if (cfg2_i !== exp2_i) begin
          $display("MISMATCH test %0d cfg2_o: expected %h, got %h",
                   test_num_i, exp2_i, cfg2_i);
        end
      end
    end
  end

  // A strobe taken while idle keeps busy_o high for one whole frame
  always @(posedge clk_i) begin
    if (reset_i) begin
      busy_left = 0;
    end else begin
      if (busy_i !== (busy_left > 0)) begin
        busy_err_count_o <= busy_err_count_o + 1;
        $display("MISMATCH busy_o: expected %h, got %h", busy_left > 0, busy_i);
      end
      if (busy_left > 0) begin
        busy_left = busy_left - 1;
      end else if (send_i) begin
        busy_left = frame_cycles_lp;
      end
    end
  end

endmodule

/* logic/config_chain_top.sv */
`timescale 1ns/1ps

module config_chain_top #(
  parameter config_pkg::node_id_t id0_p  = 4'd1,
  parameter config_pkg::node_id_t id1_p  = 4'd2,
  parameter config_pkg::node_id_t id2_p  = 4'd3,
  parameter logic [7:0]           def0_p = 8'h5A,
  parameter logic [4:0]           def1_p = 5'h11,
  parameter logic [2:0]           def2_p = 3'h5
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  send_i,
  input  config_pkg::op_t       op_i,
  input  config_pkg::node_id_t  node_id_i,
  input  config_pkg::cfg_data_t data_i,
  output logic                  busy_o,
  output logic [7:0]            cfg0_o,
  output logic [4:0]            cfg1_o,
  output logic [2:0]            cfg2_o
);

  logic ser_bit;     // Head of the chain
  logic node0_bit;   // Relay from node 0 to node 1
  logic node1_bit;   // Relay from node 1 to node 2

  config_serializer ser0 (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .send_i    (send_i),
    .op_i      (op_i),
    .node_id_i (node_id_i),
    .data_i    (data_i),
    .bit_o     (ser_bit),
    .busy_o    (busy_o)
  );

  config_node #(
    .config_bits_p (8),
    .id_p          (id0_p),
    .default_p     (def0_p)
  ) node0 (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .bit_i    (ser_bit),
    .bit_o    (node0_bit),
    .config_o (cfg0_o)
  );

  config_node #(
    .config_bits_p (5),
    .id_p          (id1_p),
    .default_p     (def1_p)
  ) node1 (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .bit_i    (node0_bit),
    .bit_o    (node1_bit),
    .config_o (cfg1_o)
  );

  config_node #(
    .config_bits_p (3),
    .id_p          (id2_p),
    .default_p     (def2_p)
  ) node2 (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .bit_i    (node1_bit),
    .bit_o    (),              // Last node, relay goes nowhere
    .config_o (cfg2_o)
  );

endmodule

/* logic/config_node.sv */
`timescale 1ns/1ps

module config_node #(
  parameter int                       config_bits_p = 8,      // At most data_width
  parameter config_pkg::node_id_t     id_p          = 4'd1,
  parameter logic [config_bits_p-1:0] default_p     = '0
) (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     bit_i,
  output logic                     bit_o,
  output logic [config_bits_p-1:0] config_o
);

  localparam int count_width_lp = $clog2(config_pkg::frame_width);
  localparam logic [count_width_lp-1:0] first_bit_lp = count_width_lp'(1);
  localparam logic [count_width_lp-1:0] last_bit_lp  =
    count_width_lp'(config_pkg::frame_width - 1);

  typedef enum logic {
    node_idle,
    node_collect
  } node_state_e;

  node_state_e                         state_r;
  logic [count_width_lp-1:0]           count_r;
  logic [config_pkg::frame_width-2:0]  shift_r;     // Holds every bit but the newest
  config_pkg::frame_t                  frame;
  config_pkg::op_t                     frame_op;
  config_pkg::node_id_t                frame_id;
  config_pkg::cfg_data_t               frame_data;
  logic                                frame_done;
  logic                                id_match;
  logic                                relay_r;
  logic [config_bits_p-1:0]            config_r;
  logic [config_bits_p-1:0]            config_n;

  // Full frame as seen on the edge that takes its last bit
  assign frame      = {bit_i, shift_r};
  assign frame_op   = frame[config_pkg::op_lsb +: config_pkg::op_width];
  assign frame_id   = frame[config_pkg::id_lsb +: config_pkg::id_width];
  assign frame_data = frame[config_pkg::data_lsb +: config_pkg::data_width];

  assign frame_done = (state_r == node_collect) && (count_r == last_bit_lp);
  assign id_match   = (frame_id == id_p);

  always_comb begin
    config_n = config_r;
    case (frame_op)
      config_pkg::OP_WRITE: begin
        if (id_match) begin
          config_n = frame_data[config_bits_p-1:0];       // Keep only what fits
        end
      end
      config_pkg::OP_DEFAULT: begin
        if (id_match) begin
          config_n = default_p;
        end
      end
      config_pkg::OP_BCAST_DEFAULT: config_n = default_p;  // Id not looked at
      default: config_n = config_r;                        // Reserved op
    endcase
  end

  always_ff @(posedge clk_i) begin
    shift_r <= frame[config_pkg::frame_width-1:1];         // Free-running LSB-first shift
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r  <= node_idle;
      count_r  <= '0;
      relay_r  <= 1'b1;                                     // Downstream sees an idle line
      config_r <= default_p;
    end else begin
      relay_r <= bit_i;
      case (state_r)
        node_idle: begin
          if (!bit_i) begin
            state_r <= node_collect;                        // Start bit seen
            count_r <= first_bit_lp;
          end
        end
        node_collect: begin
          if (frame_done) begin
            state_r  <= node_idle;
            config_r <= config_n;
          end else begin
            count_r <= count_r + 1'b1;
          end
        end
        default: state_r <= node_idle;
      endcase
    end
  end

  assign bit_o    = relay_r;
  assign config_o = config_r;

endmodule

/* logic/config_serializer.sv */
`timescale 1ns/1ps

module config_serializer (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  send_i,
  input  config_pkg::op_t       op_i,
  input  config_pkg::node_id_t  node_id_i,
  input  config_pkg::cfg_data_t data_i,
  output logic                  bit_o,
  output logic                  busy_o
);

  localparam int count_width_lp = $clog2(config_pkg::frame_width);
  localparam logic [count_width_lp-1:0] last_bit_lp =
    count_width_lp'(config_pkg::frame_width - 1);

  typedef enum logic {
    ser_idle,
    ser_send
  } ser_state_e;

  ser_state_e                state_r;
  ser_state_e                state_n;
  config_pkg::frame_t        frame_n;
  config_pkg::frame_t        shift_r;
  logic [count_width_lp-1:0] count_r;
  logic                      start;
  logic                      last_bit;

  // Start bit is a 0 at the LSB, fields follow LSB first
  assign frame_n = {data_i, node_id_i, op_i, 1'b0};

  assign start    = (state_r == ser_idle) && send_i;        // Strobes while busy are dropped
  assign last_bit = (state_r == ser_send) && (count_r == last_bit_lp);

  always_comb begin
    state_n = state_r;
    case (state_r)
      ser_idle: begin
        if (start) begin
          state_n = ser_send;
        end
      end
      ser_send: begin
        if (last_bit) begin
          state_n = ser_idle;                               // Line back to 1 next cycle
        end
      end
      default: begin
        state_n = ser_idle;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= ser_idle;
      count_r <= '0;
    end else begin
      state_r <= state_n;
      if (start) begin
        count_r <= '0;                                      // Bit 0 goes out first
      end else if ((state_r == ser_send) && !last_bit) begin
        count_r <= count_r + 1'b1;
      end
    end
  end

  // Frame shifter, the bit on the line is always shift_r[0]
  always_ff @(posedge clk_i) begin
    if (start) begin
      shift_r <= frame_n;
    end else if (state_r == ser_send) begin
      shift_r <= {1'b1, shift_r[config_pkg::frame_width-1:1]};  // Fill with idle level
    end
  end

  assign bit_o  = (state_r == ser_send) ? shift_r[0] : 1'b1;  // Idle line is high
  assign busy_o = (state_r == ser_send);

endmodule

/* logic/config_pkg.sv */
package config_pkg;

  // Frame field widths
  localparam int id_width    = 4;
  localparam int data_width  = 8;                   // Also the widest node register
  localparam int op_width    = 2;
  localparam int frame_width = 1 + op_width + id_width + data_width;

  // Field positions, start bit sits at bit 0 and goes out first
  localparam int op_lsb   = 1;
  localparam int id_lsb   = op_lsb + op_width;
  localparam int data_lsb = id_lsb + id_width;

  typedef logic [id_width-1:0]    node_id_t;        // Valid ids 1..14
  typedef logic [data_width-1:0]  cfg_data_t;
  typedef logic [op_width-1:0]    op_t;
  typedef logic [frame_width-1:0] frame_t;

  // Op codes
  localparam op_t OP_WRITE         = 2'd0;          // Addressed node loads data
  localparam op_t OP_DEFAULT       = 2'd1;          // Addressed node reloads default
  localparam op_t OP_BCAST_DEFAULT = 2'd2;          // All nodes reload default, id ignored
  localparam op_t OP_RESERVED      = 2'd3;          // No effect

endpackage
